// ==== flist.f ====
+incdir+include
rtl/tlb_pkg.sv
rtl/tlb_way.sv
rtl/tlb_hit_select.sv
rtl/tlb_victim.sv
rtl/tlb_perm_check.sv
rtl/tlb_ctrl.sv
rtl/tlb_top.sv
testbench/tlb_checker.sv
testbench/tb_tlb.sv

// ==== Makefile ====
VERILATOR ?= verilator
FLAGS     ?= --timing
TOP       ?= tb_tlb
FLIST     ?= flist.f
OBJ_DIR   ?= obj_dir

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(FLAGS) -f $(FLIST) --top-module $(TOP)

sim:
	$(VERILATOR) --binary -j 0 $(FLAGS) -f $(FLIST) --top-module $(TOP) --Mdir $(OBJ_DIR)
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "Test OK"

clean:
	rm -rf $(OBJ_DIR)

// ==== testbench/tb_tlb.sv ====
`timescale 1ns/1ps
`default_nettype none
`include "tlb_macros.svh"

module tb_tlb;
	import tlb_pkg::*;

	localparam int RESET_CYCLES = 10;

	// access tags with bit 0 as valid up to bit 7 as dirty.
	localparam logic [7:0] ACC_RWXU = 8'h1f;
	localparam logic [7:0] ACC_RO   = 8'h03;  // supervisor read only.
	localparam logic [7:0] ACC_RWU  = 8'h17;  // user read write, no execute.
	localparam logic [7:0] PASS     = 8'hdf;

	typedef struct packed {
		logic [8*12-1:0]       name;
		logic                  res;
		logic                  wr;
		logic                  inv;
		logic [`TLB_VPN_W-1:0] vpn;
		tlb_kind_t             kind;
		logic                  user;
		logic                  en;
		tlb_fill_t             fill;
		logic                  miss;
		logic                  fault;
		logic [`TLB_PPN_W-1:0] phys;
		logic [7:0]            acc;
	} row_t;

	logic                  clk;
	logic                  rst_n;
	logic                  resolve;
	logic [`TLB_VPN_W-1:0] vpn;
	tlb_kind_t             kind;
	logic                  user;
	logic                  enable;
	logic                  write;
	tlb_fill_t             fill;
	logic                  invalidate;
	logic                  done;
	logic                  miss;
	logic                  fault;
	logic [`TLB_PPN_W-1:0] phys;
	logic [7:0]            acc;

	logic                  exp_push;
	logic [8*12-1:0]       exp_name;
	logic                  exp_miss;
	logic                  exp_fault;
	logic [`TLB_PPN_W-1:0] exp_phys;
	logic [7:0]            exp_acc;
	int                    value_errors;
	int                    pulse_errors;
	int                    retired;

	row_t rows [$];
	int   pushed;
	int   limit;
	int   cycles = 0;

	tlb_top dut (
		.clk, .rst_n, .resolve, .vpn, .kind, .user, .enable,
		.write, .fill, .invalidate,
		.done, .miss, .fault, .phys, .acc
	);

	tlb_checker u_checker (
		.clk, .rst_n, .done, .miss, .fault, .phys, .acc,
		.exp_push, .exp_name, .exp_miss, .exp_fault, .exp_phys, .exp_acc,
		.value_errors, .pulse_errors, .retired
	);

	initial begin
		clk = 1'b0;
		forever #5 clk = ~clk;
	end

	task automatic lookup(input logic [8*12-1:0] name, input logic [`TLB_VPN_W-1:0] v,
			input tlb_kind_t k, input logic u, input logic en, input logic m,
			input logic flt, input logic [`TLB_PPN_W-1:0] p, input logic [7:0] a);
		row_t r;
		r = '0;
		r.name = name;
		r.res = 1'b1;
		r.vpn = v;
		r.kind = k;
		r.user = u;
		r.en = en;
		r.miss = m;
		r.fault = flt;
		r.phys = p;
		r.acc = a;
		rows.push_back(r);
	endtask

	task automatic refill(input logic [8*12-1:0] name, input logic [`TLB_VPN_W-1:0] v,
			input logic [`TLB_PPN_W-1:0] p, input logic [7:0] a);
		row_t r;
		r = '0;
		r.name = name;
		r.wr = 1'b1;
		r.fill.vpn = v;
		r.fill.ppn = p;
		r.fill.acc.raw = a;
		rows.push_back(r);
	endtask

	task automatic flush(input logic [8*12-1:0] name);
		row_t r;
		r = '0;
		r.name = name;
		r.inv = 1'b1;
		rows.push_back(r);
	endtask

	// folds the last two rows into one cycle with both strobes.
	task automatic merge_rows(input logic [8*12-1:0] name);
		row_t a;
		row_t b;
		b = rows.pop_back();
		a = rows.pop_back();
		a = row_t'(a | b);
		a.name = name;
		rows.push_back(a);
	endtask

	task automatic build_table();
		lookup("off_reset", 20'h12345, KIND_LOAD, 1'b1, 1'b0, 1'b0, 1'b0, 22'h012345, PASS);
		refill("fill_a", 20'habcd1, 22'h02a001, ACC_RWXU);
		lookup("hit_a", 20'habcd1, KIND_LOAD, 1'b0, 1'b1, 1'b0, 1'b0, 22'h02a001, ACC_RWXU);
		lookup("tag_miss", 20'habce1, KIND_LOAD, 1'b0, 1'b1, 1'b1, 1'b0, '0, '0);
		lookup("empty_set", 20'habcd2, KIND_LOAD, 1'b0, 1'b1, 1'b1, 1'b0, '0, '0);
		lookup("off_filled", 20'habcd1, KIND_STORE, 1'b1, 1'b0, 1'b0, 1'b0, 22'h0abcd1, PASS);
		// set 5 fills ways 0 to 3, then round robin takes way 0 and way 1.
		refill("fill_r1", 20'h00015, 22'h100001, ACC_RWXU);
		refill("fill_r2", 20'h00025, 22'h100002, ACC_RWXU);
		refill("fill_r3", 20'h00035, 22'h100003, ACC_RWXU);
		refill("fill_r4", 20'h00045, 22'h100004, ACC_RWXU);
		refill("fill_r5", 20'h00055, 22'h100005, ACC_RWXU);
		lookup("evicted_r1", 20'h00015, KIND_LOAD, 1'b0, 1'b1, 1'b1, 1'b0, '0, '0);
		lookup("kept_r2", 20'h00025, KIND_LOAD, 1'b0, 1'b1, 1'b0, 1'b0, 22'h100002, ACC_RWXU);
		lookup("kept_r3", 20'h00035, KIND_LOAD, 1'b0, 1'b1, 1'b0, 1'b0, 22'h100003, ACC_RWXU);
		lookup("kept_r4", 20'h00045, KIND_LOAD, 1'b0, 1'b1, 1'b0, 1'b0, 22'h100004, ACC_RWXU);
		lookup("kept_r5", 20'h00055, KIND_LOAD, 1'b0, 1'b1, 1'b0, 1'b0, 22'h100005, ACC_RWXU);
		refill("fill_r6", 20'h00065, 22'h100006, ACC_RWXU);
		lookup("evicted_r2", 20'h00025, KIND_LOAD, 1'b0, 1'b1, 1'b1, 1'b0, '0, '0);
		lookup("hit_r6", 20'h00065, KIND_LOAD, 1'b0, 1'b1, 1'b0, 1'b0, 22'h100006, ACC_RWXU);
		// a page filled twice answers from the lower way.
		refill("dup_first", 20'h0070b, 22'h0d070b, ACC_RWXU);
		refill("dup_second", 20'h0070b, 22'h0e070b, ACC_RO);
		lookup("dup_low_way", 20'h0070b, KIND_LOAD, 1'b0, 1'b1, 1'b0, 1'b0, 22'h0d070b, ACC_RWXU);
		refill("fill_ro", 20'h00107, 22'h00a107, ACC_RO);
		refill("fill_rwu", 20'h00208, 22'h00b208, ACC_RWU);
		lookup("ro_load", 20'h00107, KIND_LOAD, 1'b0, 1'b1, 1'b0, 1'b0, 22'h00a107, ACC_RO);
		lookup("ro_store", 20'h00107, KIND_STORE, 1'b0, 1'b1, 1'b0, 1'b1, 22'h00a107, ACC_RO);
		lookup("user_on_sup", 20'h00107, KIND_LOAD, 1'b1, 1'b1, 1'b0, 1'b1, 22'h00a107, ACC_RO);
		lookup("nox_fetch", 20'h00208, KIND_FETCH, 1'b1, 1'b1, 1'b0, 1'b1, 22'h00b208, ACC_RWU);
		lookup("rwu_store", 20'h00208, KIND_STORE, 1'b1, 1'b1, 1'b0, 1'b0, 22'h00b208, ACC_RWU);
		lookup("miss_nofault", 20'h00307, KIND_STORE, 1'b1, 1'b1, 1'b1, 1'b0, '0, '0);
		flush("flush_all");
		lookup("flushed_a", 20'habcd1, KIND_LOAD, 1'b0, 1'b1, 1'b1, 1'b0, '0, '0);
		lookup("flushed_r5", 20'h00055, KIND_LOAD, 1'b0, 1'b1, 1'b1, 1'b0, '0, '0);
		lookup("flushed_ro", 20'h00107, KIND_LOAD, 1'b0, 1'b1, 1'b1, 1'b0, '0, '0);
		refill("fill_x", 20'h00403, 22'h0c0403, ACC_RWXU);
		refill("", 20'h00509, 22'h0c0509, ACC_RWXU);
		flush("");
		merge_rows("wr_over_inv");
		lookup("kept_x", 20'h00403, KIND_LOAD, 1'b0, 1'b1, 1'b0, 1'b0, 22'h0c0403, ACC_RWXU);
		lookup("won_y", 20'h00509, KIND_LOAD, 1'b0, 1'b1, 1'b0, 1'b0, 22'h0c0509, ACC_RWXU);
		lookup("", 20'h0060a, KIND_LOAD, 1'b0, 1'b1, 1'b1, 1'b0, '0, '0);
		refill("", 20'h0060a, 22'h0c060a, ACC_RWXU);
		merge_rows("res_over_wr");
		lookup("dropped_wr", 20'h0060a, KIND_LOAD, 1'b0, 1'b1, 1'b1, 1'b0, '0, '0);
	endtask

	task automatic apply_row(input row_t r);
		resolve <= r.res;
		write <= r.wr;
		invalidate <= r.inv;
		vpn <= r.vpn;
		kind <= r.kind;
		user <= r.user;
		enable <= r.en;
		fill <= r.fill;
		exp_push <= r.res;  // checker expects done one cycle after dut samples it.
		exp_name <= r.name;
		exp_miss <= r.miss;
		exp_fault <= r.fault;
		exp_phys <= r.phys;
		exp_acc <= r.acc;
		if (r.res) begin
			pushed++;
		end
	endtask

	initial begin
		build_table();
		limit = 4 * rows.size() + RESET_CYCLES + 20;
		pushed = 0;
		rst_n = 1'b0;
		resolve = 1'b0;
		vpn = '0;
		kind = KIND_LOAD;
		user = 1'b0;
		enable = 1'b0;
		write = 1'b0;
		fill = '0;
		invalidate = 1'b0;
		exp_push = 1'b0;
		exp_name = '0;
		exp_miss = 1'b0;
		exp_fault = 1'b0;
		exp_phys = '0;
		exp_acc = '0;
		repeat (RESET_CYCLES) @(posedge clk);
		rst_n <= 1'b1;
		foreach (rows[i]) begin
			@(posedge clk);
			apply_row(rows[i]);
		end
		@(posedge clk);
		apply_row('0);
		while (retired < pushed) begin
			@(posedge clk);
		end
		repeat (3) @(posedge clk);  // room for a stray done.
		@(negedge clk);
		$display("value errors: %0d, done pulse errors: %0d", value_errors, pulse_errors);
		if (value_errors == 0 && pulse_errors == 0) begin
			$display("Test OK");
		end else begin
			$display("Test FAILED");
		end
		$finish;
	end

	always @(posedge clk) begin
		cycles <= cycles + 1;
		if (cycles >= limit) begin
			$display("timeout: run did not finish within %0d cycles", limit);
			$display("Test FAILED");
			$finish;
		end
	end

endmodule

`default_nettype wire

// ==== testbench/tlb_checker.sv ====
`timescale 1ns/1ps
`default_nettype none
`include "tlb_macros.svh"

module tlb_checker (
	input  wire                  clk,
	input  wire                  rst_n,
	input  wire                  done,
	input  wire                  miss,
	input  wire                  fault,
	input  wire [`TLB_PPN_W-1:0] phys,
	input  wire [7:0]            acc,
	input  wire                  exp_push,
	input  wire [8*12-1:0]       exp_name,
	input  wire                  exp_miss,
	input  wire                  exp_fault,
	input  wire [`TLB_PPN_W-1:0] exp_phys,
	input  wire [7:0]            exp_acc,
	output int                   value_errors,
	output int                   pulse_errors,
	output int                   retired
);
	typedef struct packed {
		logic [8*12-1:0]       name;
		logic                  miss;
		logic                  fault;
		logic [`TLB_PPN_W-1:0] phys;
		logic [7:0]            acc;
	} expect_t;

	expect_t exp_q [$];
	expect_t cur;
	logic    due;  // a resolve was sampled at the last edge.

	task automatic check_value(input logic [8*12-1:0] name, input string field,
			input logic [31:0] expv, input logic [31:0] actv);
		if (expv !== actv) begin
			$display("ERROR %s: %s expected 0x%0h, actual 0x%0h", name, field, expv, actv);
			value_errors++;
		end
	endtask

	always @(posedge clk) begin
		if (!rst_n) begin
			exp_q.delete();
			due = 1'b0;
			value_errors = 0;
			pulse_errors = 0;
			retired = 0;
		end else begin
			if (done && !due) begin
				$display("done pulse seen with no resolve one cycle before it");
				pulse_errors++;
			end else if (done) begin
				cur = exp_q.pop_front();
				retired++;
				check_value(cur.name, "miss", 32'(cur.miss), 32'(miss));
				check_value(cur.name, "fault", 32'(cur.fault), 32'(fault));
				// page and tag carry no meaning on a miss.
				if (!cur.miss) begin
					check_value(cur.name, "phys", 32'(cur.phys), 32'(phys));
					check_value(cur.name, "acc", 32'(cur.acc), 32'(acc));
				end
			end else if (due) begin
				cur = exp_q.pop_front();
				retired++;
				$display("no done pulse one cycle after resolve %s", cur.name);
				pulse_errors++;
			end
			if (exp_push) begin
				exp_q.push_back({exp_name, exp_miss, exp_fault, exp_phys, exp_acc});
			end
			due = exp_push;
		end
	end

endmodule

`default_nettype wire

// ==== rtl/tlb_top.sv ====
`timescale 1ns/1ps
`default_nettype none
`include "tlb_macros.svh"

module tlb_top (
	input  wire                       clk,
	input  wire                       rst_n,
	input  wire                       resolve,
	input  wire [`TLB_VPN_W-1:0]      vpn,
	input  wire tlb_pkg::tlb_kind_t   kind,
	input  wire                       user,
	input  wire                       enable,
	input  wire                       write,
	input  wire tlb_pkg::tlb_fill_t   fill,
	input  wire                       invalidate,
	output logic                      done,
	output logic                      miss,
	output logic                      fault,
	output logic [`TLB_PPN_W-1:0]     phys,
	output logic [7:0]                acc
);
	import tlb_pkg::*;

	tlb_req_t                    req_r;
	tlb_result_t [`TLB_WAYS-1:0] looks;
	tlb_result_t                 sel;
	logic [`TLB_WAYS-1:0]        way_we;
	logic [`TLB_WAYS-1:0]        valids;
	logic [`TLB_WAYS-1:0]        victim;
	logic                        inval;

	tlb_ctrl u_ctrl (
		.clk, .rst_n, .resolve, .vpn, .kind, .user, .enable,
		.write, .victim, .invalidate,
		.req_r, .way_we, .inval, .done
	);

	for (genvar w = 0; w < `TLB_WAYS; w++) begin : g_way
		tlb_way #(.SET_W(`TLB_SET_W)) u_way (
			.clk, .rst_n,
			.req(req_r),
			.we(way_we[w]),
			.fill,
			.inval,
			.look(looks[w]),
			.fill_valid(valids[w])
		);
	end

	tlb_hit_select u_hit (.looks, .req(req_r), .sel, .miss);

	tlb_victim u_victim (.clk, .rst_n, .fill, .write_go(|way_we), .valids, .victim);

	tlb_perm_check u_perm (.sel, .req(req_r), .miss, .fault);

	assign phys = sel.ppn;
	assign acc = sel.acc.raw;

endmodule

`default_nettype wire

// ==== rtl/tlb_ctrl.sv ====
`timescale 1ns/1ps
`default_nettype none
`include "tlb_macros.svh"

module tlb_ctrl (
	input  wire                        clk,
	input  wire                        rst_n,
	input  wire                        resolve,
	input  wire [`TLB_VPN_W-1:0]       vpn,
	input  wire tlb_pkg::tlb_kind_t    kind,
	input  wire                        user,
	input  wire                        enable,
	input  wire                        write,
	input  wire [`TLB_WAYS-1:0]        victim,
	input  wire                        invalidate,
	output tlb_pkg::tlb_req_t          req_r,
	output logic [`TLB_WAYS-1:0]       way_we,
	output logic                       inval,
	output logic                       done
);
	import tlb_pkg::*;

	tlb_req_t req_in;
	logic     wr_go;
	logic     inv_go;

	// resolve over write over invalidate, losers are dropped.
	assign wr_go  = write && !resolve;
	assign inv_go = invalidate && !resolve && !write;

	always_comb begin
		req_in.vpn = vpn;
		req_in.kind = kind;
		req_in.user = user;
		req_in.enable = enable;
	end

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			req_r <= '0;  // enable low gives a clean pass-through.
			done <= 1'b0;
		end else begin
			done <= resolve;
			if (resolve) begin
				req_r <= req_in;
			end
		end
	end

	assign way_we = wr_go ? victim : '0;
	assign inval = inv_go;

endmodule

`default_nettype wire

// ==== rtl/tlb_perm_check.sv ====
`timescale 1ns/1ps
`default_nettype none

module tlb_perm_check (
	input  wire tlb_pkg::tlb_result_t sel,
	input  wire tlb_pkg::tlb_req_t    req,
	input  wire                       miss,
	output logic                      fault
);
	import tlb_pkg::*;

	tlb_flags_t flags;
	logic       right_ok;
	logic       user_ok;

	assign flags = sel.acc.flags;

	always_comb begin
		case (req.kind)
			KIND_LOAD:  right_ok = flags.read;
			KIND_STORE: right_ok = flags.write;
			KIND_FETCH: right_ok = flags.exec;
			default:    right_ok = 1'b1;
		endcase
	end

	// supervisor may touch any page, user only user pages.
	assign user_ok = !req.user || flags.user;

	assign fault = !miss && (!right_ok || !user_ok);

endmodule

`default_nettype wire

// ==== rtl/tlb_victim.sv ====
`timescale 1ns/1ps
`default_nettype none
`include "tlb_macros.svh"

module tlb_victim (
	input  wire                      clk,
	input  wire                      rst_n,
	input  wire tlb_pkg::tlb_fill_t  fill,
	input  wire                      write_go,
	input  wire [`TLB_WAYS-1:0]      valids,
	output logic [`TLB_WAYS-1:0]     victim
);
	localparam int SETS  = 2**`TLB_SET_W;
	localparam int PTR_W = $clog2(`TLB_WAYS);

	logic [PTR_W-1:0]     ptr [SETS];  // round robin pointer per set.
	logic [`TLB_SET_W-1:0] set;
	logic                 found;

	assign set = fill.vpn[`TLB_SET_W-1:0];

	always_comb begin
		victim = '0;
		found = 1'b0;
		for (int i = 0; i < `TLB_WAYS; i++) begin
			if (!valids[i] && !found) begin
				victim[i] = 1'b1;
				found = 1'b1;
			end
		end
		if (!found) begin
			victim[ptr[set]] = 1'b1;
		end
	end

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			for (int s = 0; s < SETS; s++) begin
				ptr[s] <= '0;
			end
		end else if (write_go && (&valids)) begin
			ptr[set] <= ptr[set] + 1'b1;  // wraps modulo way count.
		end
	end

endmodule

`default_nettype wire

// ==== rtl/tlb_hit_select.sv ====
`timescale 1ns/1ps
`default_nettype none
`include "tlb_macros.svh"

module tlb_hit_select (
	input  wire tlb_pkg::tlb_result_t [`TLB_WAYS-1:0] looks,
	input  wire tlb_pkg::tlb_req_t                    req,
	output tlb_pkg::tlb_result_t                      sel,
	output logic                                      miss
);
	import tlb_pkg::*;

	tlb_result_t pick;

	always_comb begin
		pick = '0;
		// scan downward so the lowest hitting way is left standing.
		for (int i = `TLB_WAYS - 1; i >= 0; i--) begin
			if (looks[i].hit) begin
				pick = looks[i];
			end
		end
	end

	always_comb begin
		if (!req.enable) begin
			sel.hit = 1'b1;
			sel.ppn = {{(`TLB_PPN_W - `TLB_VPN_W){1'b0}}, req.vpn};  // zero extended.
			sel.acc.raw = `TLB_PASS_TAG;
			miss = 1'b0;
		end else begin
			sel = pick;
			miss = !pick.hit;
		end
	end

endmodule

`default_nettype wire

// ==== rtl/tlb_way.sv ====
`timescale 1ns/1ps
`default_nettype none
`include "tlb_macros.svh"

module tlb_way #(
	parameter int SET_W = 4
) (
	input  wire                    clk,
	input  wire                    rst_n,
	input  wire tlb_pkg::tlb_req_t req,
	input  wire                    we,
	input  wire tlb_pkg::tlb_fill_t fill,
	input  wire                    inval,
	output tlb_pkg::tlb_result_t   look,
	output logic                   fill_valid
);
	import tlb_pkg::*;

	localparam int SETS  = 2**SET_W;
	localparam int TAG_W = `TLB_VPN_W - SET_W;

	logic [SETS-1:0]       valid;
	logic [TAG_W-1:0]      tag_mem [SETS];
	logic [`TLB_PPN_W-1:0] ppn_mem [SETS];
	logic [7:1]            acc_mem [SETS];  // bit 0 lives in valid.

	logic [SET_W-1:0] rd_set;
	logic [SET_W-1:0] wr_set;
	logic [TAG_W-1:0] rd_tag;
	logic [TAG_W-1:0] wr_tag;
	tlb_access_u      rd_acc;

	// |tag|set index| split of the page number.
	assign rd_set = req.vpn[SET_W-1:0];
	assign rd_tag = req.vpn[`TLB_VPN_W-1:SET_W];
	assign wr_set = fill.vpn[SET_W-1:0];
	assign wr_tag = fill.vpn[`TLB_VPN_W-1:SET_W];

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			valid <= '0;
		end else if (inval) begin
			valid <= '0;  // flush every set at once.
		end else if (we) begin
			valid[wr_set] <= fill.acc.flags.valid;
		end
	end

	always_ff @(posedge clk) begin
		if (we) begin
			tag_mem[wr_set] <= wr_tag;
			ppn_mem[wr_set] <= fill.ppn;
			acc_mem[wr_set] <= fill.acc.raw[7:1];
		end
	end

	assign rd_acc.raw = {acc_mem[rd_set], valid[rd_set]};

	assign look.hit = valid[rd_set] && (tag_mem[rd_set] == rd_tag);
	assign look.ppn = ppn_mem[rd_set];
	assign look.acc = rd_acc;

	// occupancy of the refill set, for victim choice.
	assign fill_valid = valid[wr_set];

endmodule

`default_nettype wire

// ==== rtl/tlb_pkg.sv ====
`default_nettype none
`include "tlb_macros.svh"

package tlb_pkg;

	// bit 0 is valid, bit 7 is dirty.
	typedef struct packed {
		logic dirty;
		logic accessed;
		logic gbl;
		logic user;
		logic exec;
		logic write;
		logic read;
		logic valid;
	} tlb_flags_t;

	typedef union packed {
		logic [7:0] raw;
		tlb_flags_t flags;
	} tlb_access_u;

	typedef enum logic [1:0] {
		KIND_LOAD  = 2'd0,
		KIND_STORE = 2'd1,
		KIND_FETCH = 2'd2
	} tlb_kind_t;

	typedef struct packed {
		logic [`TLB_VPN_W-1:0] vpn;
		tlb_kind_t kind;
		logic user;
		logic enable;
	} tlb_req_t;

	typedef struct packed {
		logic [`TLB_VPN_W-1:0] vpn;
		logic [`TLB_PPN_W-1:0] ppn;
		tlb_access_u acc;
	} tlb_fill_t;

	typedef struct packed {
		logic hit;
		logic [`TLB_PPN_W-1:0] ppn;
		tlb_access_u acc;
	} tlb_result_t;

endpackage

`default_nettype wire

// ==== include/tlb_macros.svh ====
`ifndef TLB_MACROS_SVH
`define TLB_MACROS_SVH

// virtual and physical page number widths.
`define TLB_VPN_W 20
`define TLB_PPN_W 22

// low vpn bits pick the set, 16 sets.
`define TLB_SET_W 4

// number of ways searched in parallel.
`define TLB_WAYS 4

// tag given out when translation is off.
// read, write, execute, user, accessed, dirty, not global.
`define TLB_PASS_TAG 8'b11011111

`endif
